//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_sdram_ctrl
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/sdram_cmd_sequencer.sv
module sdram_cmd_sequencer
  import sdram_pkg::*;
#(
  parameter int T_RCD = 3,
  parameter int T_RP  = 3,
  parameter int T_RFC = 10
)
(
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  logic                 req,
  input  logic                 we,
  input  logic [ADDR_W-1:0]    addr,
  input  logic                 refresh_strobe,
  output logic                 grant,
  output sdram_cmd_e           cmd,
  output logic [SDRAM_A_W-1:0] sdram_a,
  output logic [BANK_W-1:0]    ba,
  output logic                 wr_issue,
  output logic                 rd_issue
);

  // The issue cycle and the NOOP gap already cover two cycles of every wait
  localparam int CNT_W = $clog2(T_RCD + T_RP + T_RFC + 2);
  localparam logic [CNT_W-1:0] LD_RCD = CNT_W'((T_RCD > 2) ? T_RCD - 2 : 0);
  localparam logic [CNT_W-1:0] LD_RP  = CNT_W'((T_RP > 2) ? T_RP - 2 : 0);
  localparam logic [CNT_W-1:0] LD_RFC = CNT_W'((T_RFC > 2) ? T_RFC - 2 : 0);

  seq_state_e              state;
  seq_state_e              ret_state;
  logic                    page_open;
  logic [PAGE_W-1:0]       page_tag;
  logic                    ref_ack;
  logic [CNT_W-1:0]        cnt;

  logic                    refresh_pend;
  logic                    decide;
  logic                    page_hit;
  logic [PAGE_W-1:0]       req_page;
  logic [ROW_W-1:0]        row;
  logic [BANK_W-1:0]       bank;
  logic [COL_W-1:0]        col;
  sdram_cmd_e              nxt_cmd;
  logic [SDRAM_A_W-1:0]    nxt_a;
  logic [BANK_W-1:0]       nxt_ba;
  logic [CNT_W-1:0]        nxt_load;

  assign row      = addr[ROW_LSB +: ROW_W];
  assign bank     = addr[BANK_LSB +: BANK_W];
  assign col      = addr[COL_W-1:0];
  assign req_page = addr[BANK_LSB +: PAGE_W];

  assign refresh_pend = refresh_strobe ^ ref_ack;
  assign page_hit     = page_open && (req_page == page_tag);
  assign decide       = (state == st_idle) || (state == st_open);
  assign ret_state    = page_open ? st_open : st_idle;

  // --------------------
  // Command choice
  // --------------------
  always_comb
  begin
    nxt_cmd = cmd_noop;
    if (decide)
    begin
      if (refresh_pend)
        nxt_cmd = page_open ? cmd_prch : cmd_arsr;   // Close the row before refresh
      else if (req)
      begin
        if (page_hit)
          nxt_cmd = we ? cmd_wrte : cmd_read;
        else if (page_open)
          nxt_cmd = cmd_prch;                       // Page miss
        else
          nxt_cmd = cmd_actv;
      end
    end
  end

  always_comb
  begin
    nxt_a    = PRCH_ALL_ADDR;
    nxt_ba   = '0;
    nxt_load = '0;
    case (nxt_cmd)
      cmd_actv:
      begin
        nxt_a    = {row[ROW_W-1:ROW_W-2], 1'b0, row[ROW_W-3:0]};  // Row split around A10
        nxt_ba   = bank;
        nxt_load = LD_RCD;
      end
      cmd_read, cmd_wrte:
      begin
        nxt_a  = {col, 1'b0};
        nxt_ba = bank;
      end
      cmd_prch: nxt_load = LD_RP;
      cmd_arsr: nxt_load = LD_RFC;
      default: nxt_load = '0;
    endcase
  end

  // --------------------
  // Registered outputs
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      cmd      <= cmd_noop;
      sdram_a  <= PRCH_ALL_ADDR;
      ba       <= '0;
      grant    <= 1'b0;
      wr_issue <= 1'b0;
      rd_issue <= 1'b0;
    end
    else
    begin
      cmd      <= nxt_cmd;
      sdram_a  <= nxt_a;
      ba       <= nxt_ba;
      grant    <= (nxt_cmd == cmd_read) || (nxt_cmd == cmd_wrte);
      wr_issue <= (nxt_cmd == cmd_wrte);
      rd_issue <= (nxt_cmd == cmd_read);
    end
  end

  // --------------------
  // Page and timer state
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      state     <= st_idle;
      page_open <= 1'b0;
      ref_ack   <= 1'b0;
      cnt       <= '0;
    end
    else
    begin
      case (state)
        st_gap:
          state <= (cnt != '0) ? st_wait : ret_state;
        st_wait:
        begin
          cnt <= cnt - 1'b1;
          if (cnt == CNT_W'(1))
            state <= ret_state;
        end
        default:
        begin
          if (nxt_cmd != cmd_noop)
          begin
            state <= st_gap;
            cnt   <= nxt_load;
          end
          else
            state <= ret_state;
          if (nxt_cmd == cmd_actv)
            page_open <= 1'b1;
          if (nxt_cmd == cmd_prch)
            page_open <= 1'b0;
          if (nxt_cmd == cmd_arsr)
            ref_ack <= refresh_strobe;              // Refresh acknowledged
        end
      endcase
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (decide && (nxt_cmd == cmd_actv))
      page_tag <= req_page;
  end

  a_rw_page_open: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (cmd inside {cmd_read, cmd_wrte}) |-> page_open);

  a_noop_gap: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (cmd != cmd_noop) |=> (cmd == cmd_noop));

endmodule

//--- logic/sdram_ctrl_top.sv
module sdram_ctrl_top
  import sdram_pkg::*;
#(
  parameter int T_RCD         = 3,
  parameter int T_RP          = 3,
  parameter int T_RFC         = 10,
  parameter int CAS_LATENCY   = 2,
  parameter int WRITE_LATENCY = 1
)
(
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  // User side
  input  logic                 req,
  input  logic                 we,
  input  logic [ADDR_W-1:0]    addr,
  input  logic [DQ_W-1:0]      data_w,
  input  logic [DM_W-1:0]      byte_en,
  input  logic                 refresh_strobe,
  output logic                 grant,
  output logic [DQ_W-1:0]      data_r,
  output logic                 data_r_valid,
  // SDRAM side
  output sdram_cmd_e           cmd,
  output logic [SDRAM_A_W-1:0] sdram_a,
  output logic [BANK_W-1:0]    ba,
  output logic [DM_W-1:0]      dm,
  output logic [DQ_W-1:0]      dq_out,
  output logic [DQ_W-1:0]      dq_oe,
  input  logic [DQ_W-1:0]      dq_in
);

  logic            wr_issue;
  logic            rd_issue;
  logic [DQ_W-1:0] lane_d;
  logic            lane_oe;
  logic [DQ_W-1:0] lane_q;

  sdram_cmd_sequencer #(
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RFC (T_RFC)
  ) i_seq (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .req            (req),
    .we             (we),
    .addr           (addr),
    .refresh_strobe (refresh_strobe),
    .grant          (grant),
    .cmd            (cmd),
    .sdram_a        (sdram_a),
    .ba             (ba),
    .wr_issue       (wr_issue),
    .rd_issue       (rd_issue)
  );

  sdram_write_path #(
    .WRITE_LATENCY (WRITE_LATENCY)
  ) i_wr (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .wr_issue  (wr_issue),
    .data_w    (data_w),
    .byte_en   (byte_en),
    .lane_d    (lane_d),
    .lane_oe   (lane_oe),
    .dm        (dm)
  );

  sdram_read_capture #(
    .CAS_LATENCY (CAS_LATENCY)
  ) i_rd (
    .INPUT_CLK    (INPUT_CLK),
    .RST          (RST),
    .rd_issue     (rd_issue),
    .lane_q       (lane_q),
    .data_r       (data_r),
    .data_r_valid (data_r_valid)
  );

  // --------------------
  // DQ bit slices
  // --------------------
  generate
    for (genvar i = 0; i < DQ_W; i++)
    begin : g_lane
      sdram_dq_lane i_lane (
        .INPUT_CLK (INPUT_CLK),
        .RST       (RST),
        .d         (lane_d[i]),
        .oe        (lane_oe),               // Shared enable
        .pin_in    (dq_in[i]),
        .pin_out   (dq_out[i]),
        .pin_oe    (dq_oe[i]),
        .q         (lane_q[i])
      );
    end
  endgenerate

endmodule

//--- logic/sdram_dq_lane.sv
module sdram_dq_lane
(
  input  logic INPUT_CLK,
  input  logic RST,
  input  logic d,
  input  logic oe,
  input  logic pin_in,
  output logic pin_out,
  output logic pin_oe,
  output logic q
);

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
      pin_oe <= 1'b0;                       // Bus released in reset
    else
      pin_oe <= oe;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    pin_out <= d;
    q       <= pin_in;                      // Sampled every cycle
  end

  a_oe_known: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    !$isunknown(pin_oe));

endmodule

//--- logic/sdram_pkg.sv
package sdram_pkg;

  // SDRAM command encodings {RAS#, CAS#, WE#}
  typedef enum logic [2:0]
  {
    cmd_mrst = 3'd0,                        // Mode register set
    cmd_arsr = 3'd1,                        // Auto refresh
    cmd_prch = 3'd2,                        // Precharge
    cmd_actv = 3'd3,                        // Row activate
    cmd_wrte = 3'd4,
    cmd_read = 3'd5,
    cmd_btrm = 3'd6,                        // Burst terminate
    cmd_noop = 3'd7
  } sdram_cmd_e;

  typedef enum logic [1:0]
  {
    st_idle,                                // No page open
    st_open,                                // Row open, ready
    st_wait,                                // Command timer running
    st_gap                                  // NOOP after a command
  } seq_state_e;

  // --------------------
  // User address layout
  // --------------------
  localparam int ADDR_W   = 26;
  localparam int ROW_LSB  = 14;
  localparam int ROW_W    = 12;
  localparam int BANK_LSB = 12;
  localparam int BANK_W   = 2;
  localparam int COL_W    = 12;
  localparam int PAGE_W   = 14;             // Bank plus row

  // --------------------
  // Device side
  // --------------------
  localparam int SDRAM_A_W = 13;
  localparam logic [SDRAM_A_W-1:0] PRCH_ALL_ADDR = 13'h400;  // A10 selects all banks
  localparam int DQ_W = 16;
  localparam int DM_W = 2;

endpackage

//--- logic/sdram_read_capture.sv
module sdram_read_capture
  import sdram_pkg::*;
#(
  parameter int CAS_LATENCY = 2
)
(
  input  logic            INPUT_CLK,
  input  logic            RST,
  input  logic            rd_issue,
  input  logic [DQ_W-1:0] lane_q,
  output logic [DQ_W-1:0] data_r,
  output logic            data_r_valid
);

  // One extra stage covers the lane input register
  logic [CAS_LATENCY:0] rd_pipe;

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      rd_pipe      <= '0;
      data_r_valid <= 1'b0;
    end
    else
    begin
      rd_pipe      <= {rd_pipe[CAS_LATENCY-1:0], rd_issue};
      data_r_valid <= rd_pipe[CAS_LATENCY];
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (rd_pipe[CAS_LATENCY])
      data_r <= lane_q;                     // Word from CL cycles after READ
  end

endmodule

//--- logic/sdram_write_path.sv
module sdram_write_path
  import sdram_pkg::*;
#(
  parameter int WRITE_LATENCY = 1
)
(
  input  logic            INPUT_CLK,
  input  logic            RST,
  input  logic            wr_issue,
  input  logic [DQ_W-1:0] data_w,
  input  logic [DM_W-1:0] byte_en,
  output logic [DQ_W-1:0] lane_d,
  output logic            lane_oe,
  output logic [DM_W-1:0] dm
);

  logic [WRITE_LATENCY-1:0] vld_sr;
  logic [DM_W-1:0]          be_sr [WRITE_LATENCY];

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
      vld_sr <= '0;
    else
    begin
      vld_sr[0] <= wr_issue;
      for (int i = 1; i < WRITE_LATENCY; i++)
        vld_sr[i] <= vld_sr[i-1];
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (wr_issue)
      be_sr[0] <= byte_en;
    for (int i = 1; i < WRITE_LATENCY; i++)
      be_sr[i] <= be_sr[i-1];
  end

  assign dm = vld_sr[WRITE_LATENCY-1] ? ~be_sr[WRITE_LATENCY-1] : '0;  // Mask is active high

  // Lanes add their own output register, so data runs one stage short
  generate
    if (WRITE_LATENCY == 1)
    begin : g_lat1
      assign lane_d  = data_w;
      assign lane_oe = wr_issue;
    end
    else
    begin : g_latn
      logic [DQ_W-1:0] data_sr [WRITE_LATENCY-1];

      always_ff @(posedge INPUT_CLK)
      begin
        if (wr_issue)
          data_sr[0] <= data_w;
        for (int i = 1; i < WRITE_LATENCY - 1; i++)
          data_sr[i] <= data_sr[i-1];
      end

      assign lane_d  = data_sr[WRITE_LATENCY-2];
      assign lane_oe = vld_sr[WRITE_LATENCY-2];
    end
  endgenerate

endmodule

//--- sim/tb_sdram_ctrl.sv
module tb_sdram_ctrl
  import sdram_pkg::*;
();

  localparam int T_RCD          = 3;
  localparam int T_RP           = 3;
  localparam int T_RFC          = 10;
  localparam int CAS_LATENCY    = 2;
  localparam int WRITE_LATENCY  = 1;
  localparam int N_RAND         = 200;
  localparam int N_DIRECTED     = 12;
  localparam int TIMEOUT_CYCLES = 40 * (N_RAND + N_DIRECTED) + 200;

  localparam logic [ADDR_W-1:0] ADDR_A = {12'hc21, 2'd1, 12'h01c};
  localparam logic [ADDR_W-1:0] ADDR_B = {12'h3f0, 2'd1, 12'h005};  // Same bank, other row
  localparam logic [ADDR_W-1:0] ADDR_C = {12'h2a5, 2'd2, 12'h033};  // Never fully written

  logic                 INPUT_CLK = 1'b0;
  logic                 RST;
  logic                 req;
  logic                 we;
  logic [ADDR_W-1:0]    addr;
  logic [DQ_W-1:0]      data_w;
  logic [DM_W-1:0]      byte_en;
  logic                 refresh_strobe;
  logic                 grant;
  logic [DQ_W-1:0]      data_r;
  logic                 data_r_valid;
  sdram_cmd_e           cmd;
  logic [SDRAM_A_W-1:0] sdram_a;
  logic [BANK_W-1:0]    ba;
  logic [DM_W-1:0]      dm;
  logic [DQ_W-1:0]      dq_out;
  logic [DQ_W-1:0]      dq_oe;
  logic [DQ_W-1:0]      dq_in = '0;

  int                   cyc = 0;
  logic [15:0]          lfsr = 16'd57748;
  logic [DQ_W-1:0]      shadow [logic [ADDR_W-1:0]];  // Expected contents
  logic [DQ_W-1:0]      mem [logic [ADDR_W-1:0]];     // Memory model contents
  logic [ROW_W-1:0]     open_row [4];
  logic [3:0]           bank_open = '0;
  logic [ADDR_W-1:0]    wr_addr_q [$];
  int                   rd_due_q [$];
  logic [DQ_W-1:0]      rd_word_q [$];
  sdram_cmd_e           log_cmd [$];
  logic [SDRAM_A_W-1:0] log_a [$];
  int                   log_base = 0;
  int                   last_any = -1000;
  int                   last_actv = -1000;
  int                   last_prch = -1000;
  int                   last_arsr = -1000;

  always #5 INPUT_CLK = ~INPUT_CLK;

  sdram_ctrl_top #(
    .T_RCD         (T_RCD),
    .T_RP          (T_RP),
    .T_RFC         (T_RFC),
    .CAS_LATENCY   (CAS_LATENCY),
    .WRITE_LATENCY (WRITE_LATENCY)
  ) i_dut (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .req            (req),
    .we             (we),
    .addr           (addr),
    .data_w         (data_w),
    .byte_en        (byte_en),
    .refresh_strobe (refresh_strobe),
    .grant          (grant),
    .data_r         (data_r),
    .data_r_valid   (data_r_valid),
    .cmd            (cmd),
    .sdram_a        (sdram_a),
    .ba             (ba),
    .dm             (dm),
    .dq_out         (dq_out),
    .dq_oe          (dq_oe),
    .dq_in          (dq_in)
  );

  // --------------------
  // Helpers and reference
  // --------------------
  task automatic fail_run(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, string exp, string act);
    fail_run($sformatf("FAILED %s: expected %s, actual %s", name, exp, act));
  endtask

  task automatic check_cmd(string name, sdram_cmd_e exp, sdram_cmd_e act);
    if (act !== exp)
      report_mismatch(name, exp.name(), act.name());
  endtask

  task automatic check_addr(string name, logic [SDRAM_A_W-1:0] exp, logic [SDRAM_A_W-1:0] act);
    if (act !== exp)
      report_mismatch(name, $sformatf("0x%h", exp), $sformatf("0x%h", act));
  endtask

  task automatic check_data(string name, logic [DQ_W-1:0] exp, logic [DQ_W-1:0] act);
    if (act !== exp)
      report_mismatch(name, $sformatf("0x%h", exp), $sformatf("0x%h", act));
  endtask

  task automatic check_mask(string name, logic [DM_W-1:0] exp, logic [DM_W-1:0] act);
    if (act !== exp)
      report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp)
      report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] take_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // Unwritten words read back as a pattern of their address
  function automatic logic [DQ_W-1:0] fill_word(logic [ADDR_W-1:0] a);
    return a[15:0] ^ {a[25:16], 6'h2a};
  endfunction

  function automatic logic [DQ_W-1:0] expected_read(logic [ADDR_W-1:0] a);
    if (shadow.exists(a))
      return shadow[a];
    return fill_word(a);
  endfunction

  task automatic ref_write(logic [ADDR_W-1:0] a, logic [DQ_W-1:0] d, logic [DM_W-1:0] be);
    logic [DQ_W-1:0] old;
    old       = expected_read(a);
    shadow[a] = {be[1] ? d[15:8] : old[15:8], be[0] ? d[7:0] : old[7:0]};
  endtask

  function automatic logic [SDRAM_A_W-1:0] row_addr(logic [ROW_W-1:0] row);
    return {row[11:10], 1'b0, row[9:0]};                // A10 left clear
  endfunction

  function automatic logic [SDRAM_A_W-1:0] col_addr(logic [COL_W-1:0] col);
    return {col, 1'b0};
  endfunction

  // --------------------
  // Memory model
  // --------------------
  always @(posedge INPUT_CLK)
  begin
    logic [ADDR_W-1:0] a;
    logic [DQ_W-1:0]   old;
    if (dq_oe == '1)
    begin
      if (wr_addr_q.size() == 0)
        fail_run("Write data appeared on DQ with no WRITE command before it");
      a      = wr_addr_q.pop_front();
      old    = mem.exists(a) ? mem[a] : fill_word(a);
      mem[a] = {dm[1] ? old[15:8] : dq_out[15:8], dm[0] ? old[7:0] : dq_out[7:0]};
    end
    if (RST === 1'b1)
    begin
      case (cmd)
        cmd_actv:
        begin
          if (bank_open != '0)
            fail_run("ACTV issued while a row was still open");
          bank_open[ba] = 1'b1;
          open_row[ba]  = {sdram_a[12:11], sdram_a[9:0]};
        end
        cmd_prch:
        begin
          if (sdram_a[10])
            bank_open = '0;
          else
            bank_open[ba] = 1'b0;
        end
        cmd_arsr:
        begin
          if (bank_open != '0)
            fail_run("ARSR issued while a row was still open");
        end
        cmd_wrte, cmd_read:
        begin
          if (!bank_open[ba])
            fail_run("READ or WRITE issued to a bank with no open row");
          a = {open_row[ba], ba, sdram_a[12:1]};
          if (cmd == cmd_wrte)
            wr_addr_q.push_back(a);
          else
          begin
            rd_due_q.push_back(cyc + CAS_LATENCY - 1);
            rd_word_q.push_back(mem.exists(a) ? mem[a] : fill_word(a));
          end
        end
        default: ;
      endcase
    end
    if ((rd_due_q.size() != 0) && (rd_due_q[0] == cyc))
    begin
      dq_in <= rd_word_q.pop_front();
      void'(rd_due_q.pop_front());
    end
    else
      dq_in <= 16'h5a5a ^ cyc[15:0];                    // Junk outside the read slot
  end

  // --------------------
  // Command stream checker
  // --------------------
  always @(posedge INPUT_CLK)
  begin
    if (RST === 1'b1)
      check_flag("grant_with_access", cmd inside {cmd_read, cmd_wrte}, grant);
    if ((RST === 1'b1) && (cmd != cmd_noop))
    begin
      if (cyc - last_any < 2)
        fail_run("A command followed the previous one without a NOOP cycle");
      if (cyc - last_prch < T_RP)
        fail_run("A command came sooner than T_RP after PRCH");
      if (cyc - last_arsr < T_RFC)
        fail_run("A command came sooner than T_RFC after ARSR");
      if ((cmd inside {cmd_read, cmd_wrte}) && (cyc - last_actv < T_RCD))
        fail_run("READ or WRITE came sooner than T_RCD after ACTV");
      last_any = cyc;
      if (cmd == cmd_actv)
        last_actv = cyc;
      if (cmd == cmd_prch)
        last_prch = cyc;
      if (cmd == cmd_arsr)
        last_arsr = cyc;
      log_cmd.push_back(cmd);
      log_a.push_back(sdram_a);
    end
  end

  always @(posedge INPUT_CLK)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES)
      fail_run($sformatf("Timeout: the tests did not finish within %0d cycles", cyc));
  end

  // --------------------
  // Test sequences
  // --------------------
  task automatic mark_log();
    log_base = log_cmd.size();
  endtask

  task automatic expect_count(string name, int n);
    if (log_cmd.size() - log_base != n)
      report_mismatch(name, $sformatf("%0d commands", n),
                      $sformatf("%0d commands", log_cmd.size() - log_base));
  endtask

  task automatic expect_cmd(string name, int idx, sdram_cmd_e c,
                            logic [SDRAM_A_W-1:0] a, logic chk_a);
    check_cmd(name, c, log_cmd[log_base + idx]);
    if (chk_a)
      check_addr(name, a, log_a[log_base + idx]);
  endtask

  task automatic do_access(string name, logic wr, logic [ADDR_W-1:0] a,
                           logic [DQ_W-1:0] d, logic [DM_W-1:0] be);
    logic [DQ_W-1:0] exp;
    exp = expected_read(a);
    @(posedge INPUT_CLK);
    req     <= 1'b1;
    we      <= wr;
    addr    <= a;
    data_w  <= d;
    byte_en <= be;
    @(posedge INPUT_CLK);
    while (grant !== 1'b1)
      @(posedge INPUT_CLK);
    req <= 1'b0;
    if (wr)
    begin
      ref_write(a, d, be);
      repeat (WRITE_LATENCY) @(negedge INPUT_CLK);
      check_data({name, "_dq_oe"}, '1, dq_oe);
      check_mask({name, "_dm"}, ~be, dm);
      check_data({name, "_dq_out"}, d, dq_out);
      @(negedge INPUT_CLK);
      check_data({name, "_dq_oe_off"}, '0, dq_oe);      // One beat only
      check_mask({name, "_dm_off"}, '0, dm);
    end
    else
    begin
      while (data_r_valid !== 1'b1)
        @(posedge INPUT_CLK);
      check_data({name, "_data_r"}, exp, data_r);
      @(negedge INPUT_CLK);
    end
  endtask

  task automatic run_random();
    logic [15:0]       bits;
    logic [DQ_W-1:0]   d;
    logic [ROW_W-1:0]  row;
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < N_RAND; i++)
    begin
      bits = take_bits(14);
      d    = take_bits(16);
      row  = {bits[0], 8'h00, bits[1], 2'b01};         // Four rows, both sides of A10
      a    = {row, bits[3:2], 9'h000, bits[6:4]};
      if (bits[13:10] == 4'h0)
      begin
        @(posedge INPUT_CLK);
        refresh_strobe <= ~refresh_strobe;
      end
      do_access($sformatf("t6_random_%0d", i), bits[7], a, d, bits[9:8]);
    end
  endtask

  initial
  begin
    RST            <= 1'b0;
    req            <= 1'b0;
    we             <= 1'b0;
    addr           <= '0;
    data_w         <= '0;
    byte_en        <= '0;
    refresh_strobe <= 1'b0;
    repeat (4) @(posedge INPUT_CLK);
    RST <= 1'b1;
    @(negedge INPUT_CLK);
    check_cmd("t1_reset_cmd", cmd_noop, cmd);
    check_addr("t1_reset_a", PRCH_ALL_ADDR, sdram_a);
    check_flag("t1_reset_grant", 1'b0, grant);
    check_flag("t1_reset_valid", 1'b0, data_r_valid);
    check_data("t1_reset_dq_oe", '0, dq_oe);
    check_mask("t1_reset_dm", '0, dm);

    mark_log();                                         // Idle start, no PRCH
    do_access("t2_write", 1'b1, ADDR_A, 16'hbeef, 2'b11);
    expect_count("t2_write_count", 2);
    expect_cmd("t2_actv", 0, cmd_actv, row_addr(ADDR_A[ROW_LSB +: ROW_W]), 1'b1);
    expect_cmd("t2_wrte", 1, cmd_wrte, col_addr(ADDR_A[COL_W-1:0]), 1'b1);
    mark_log();
    do_access("t2_read", 1'b0, ADDR_A, '0, 2'b11);
    expect_count("t2_read_count", 1);
    expect_cmd("t2_read", 0, cmd_read, col_addr(ADDR_A[COL_W-1:0]), 1'b1);

    mark_log();
    do_access("t3_write", 1'b1, ADDR_B, 16'h0f1e, 2'b11);
    expect_count("t3_write_count", 3);
    expect_cmd("t3_prch", 0, cmd_prch, PRCH_ALL_ADDR, 1'b1);
    expect_cmd("t3_actv", 1, cmd_actv, row_addr(ADDR_B[ROW_LSB +: ROW_W]), 1'b1);
    expect_cmd("t3_wrte", 2, cmd_wrte, col_addr(ADDR_B[COL_W-1:0]), 1'b1);
    do_access("t3_read_back", 1'b0, ADDR_A, '0, 2'b11);

    mark_log();
    @(posedge INPUT_CLK);
    refresh_strobe <= ~refresh_strobe;
    while (cmd !== cmd_arsr)
      @(posedge INPUT_CLK);
    @(negedge INPUT_CLK);
    expect_count("t4_refresh_count", 2);
    expect_cmd("t4_prch", 0, cmd_prch, PRCH_ALL_ADDR, 1'b1);
    expect_cmd("t4_arsr", 1, cmd_arsr, '0, 1'b0);
    mark_log();
    do_access("t4_read", 1'b0, ADDR_A, '0, 2'b11);
    expect_count("t4_read_count", 2);
    expect_cmd("t4_actv", 0, cmd_actv, row_addr(ADDR_A[ROW_LSB +: ROW_W]), 1'b1);

    do_access("t5_low_byte", 1'b1, ADDR_A, 16'h1234, 2'b01);
    do_access("t5_high_byte", 1'b1, ADDR_A, 16'habcd, 2'b10);
    do_access("t5_read_merged", 1'b0, ADDR_A, '0, 2'b11);
    do_access("t5_fill_high", 1'b1, ADDR_C, 16'h77aa, 2'b10);
    do_access("t5_read_fill", 1'b0, ADDR_C, '0, 2'b11);

    run_random();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- tb.f
logic/sdram_pkg.sv
logic/sdram_dq_lane.sv
logic/sdram_write_path.sv
logic/sdram_read_capture.sv
logic/sdram_cmd_sequencer.sv
logic/sdram_ctrl_top.sv
sim/tb_sdram_ctrl.sv
